// File: common/gl_params.svh
`ifndef GL_PARAMS_SVH
`define GL_PARAMS_SVH

// Framebuffer size in pixels
`define GL_FB_WIDTH 64
`define GL_FB_HEIGHT 32

// Word address into the framebuffer RAM
`define GL_FB_ADDR_W 11

// One color per framebuffer word
`define GL_COLOR_W 32

// Pixel FIFO entries
`define GL_FIFO_DEPTH 8

`endif

// File: common/gl_pixel_pkg.sv
`default_nettype none

`include "gl_params.svh"

package gl_pixel_pkg;

    ////////////////////////////////////////
    // Pixel level types
    ////////////////////////////////////////

    // Screen coordinate, wide enough for both axes
    typedef logic [7:0] coord_t;

    // Color word as written to the framebuffer
    typedef logic [`GL_COLOR_W-1:0] color_t;

    // One pixel produced by the rasterizer
    // 8 + 8 + 32 bits, x in the top byte
    typedef struct packed {
        coord_t x;
        coord_t y;
        color_t color;
    } pixel_rec_t;

endpackage

`default_nettype wire

// File: common/gl_mem_pkg.sv
`default_nettype none

`include "gl_params.svh"

package gl_mem_pkg;

    typedef logic [`GL_FB_ADDR_W-1:0] fb_addr_t;
    typedef logic [`GL_COLOR_W-1:0] fb_word_t;

    // Who owns the framebuffer port
    typedef enum logic [0:0] {
        FB_MASTER_HOST   = 1'b0,
        FB_MASTER_WRITER = 1'b1
    } fb_master_e;

endpackage

`default_nettype wire

// File: hw/rect_raster.sv
`timescale 1ns/100ps
`default_nettype none

module rect_raster
    import gl_pixel_pkg::*;
(
    input  wire logic       bram_clk,
    input  wire logic       rst_n,
    input  wire logic       draw_start,
    input  wire coord_t     draw_x0,
    input  wire coord_t     draw_y0,
    input  wire coord_t     draw_x1,
    input  wire coord_t     draw_y1,
    input  wire color_t     draw_color,
    input  wire logic       full,
    input  wire logic       fifo_empty,
    input  wire logic       writer_idle,
    output logic            push,
    output pixel_rec_t      push_rec,
    output logic            draw_busy
);

    logic   active;
    logic   rect_void;
    logic   accept;
    logic   last_x;
    logic   last_y;
    coord_t x0_q;
    coord_t x1_q;
    coord_t y1_q;
    coord_t cur_x;
    coord_t cur_y;
    color_t color_q;

    // Starts are ignored while a draw is still draining
    assign accept = draw_start & ~draw_busy;

    assign last_x = (cur_x == x1_q);
    assign last_y = (cur_y == y1_q);

    // An empty rectangle spends one cycle active and pushes nothing
    assign push     = active & ~rect_void & ~full;
    assign push_rec = '{x: cur_x, y: cur_y, color: color_q};

    // Busy until the last pixel has left the writer
    assign draw_busy = active | ~fifo_empty | ~writer_idle;

    ////////////////////////////////////////
    // Scan control
    ////////////////////////////////////////

    always_ff @(posedge bram_clk)
    begin
        if (!rst_n)
        begin
            active    <= 1'b0;
            rect_void <= 1'b0;
        end
        else if (accept)
        begin
            active    <= 1'b1;
            rect_void <= (draw_x0 > draw_x1) | (draw_y0 > draw_y1);
        end
        else if (active && (rect_void || (push && last_x && last_y)))
        begin
            active <= 1'b0;
        end
    end

    // Corners, color and scan position
    always_ff @(posedge bram_clk)
    begin
        if (accept)
        begin
            x0_q    <= draw_x0;
            x1_q    <= draw_x1;
            y1_q    <= draw_y1;
            color_q <= draw_color;
            cur_x   <= draw_x0;
            cur_y   <= draw_y0;
        end
        else if (push)
        begin
            // x runs fastest, then step down a row
            if (last_x)
            begin
                cur_x <= x0_q;
                cur_y <= cur_y + 8'd1;
            end
            else
            begin
                cur_x <= cur_x + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "gl_params.svh"

module pixel_fifo
    import gl_pixel_pkg::*;
(
    input  wire logic       bram_clk,
    input  wire logic       rst_n,
    input  wire logic       push,
    input  wire pixel_rec_t push_rec,
    input  wire logic       pop,
    output pixel_rec_t      head_rec,
    output logic            full,
    output logic            empty
);

    localparam int DEPTH = `GL_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    pixel_rec_t       buf_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Fall-through head
    assign head_rec = buf_q[rd_ptr];

    always_ff @(posedge bram_clk)
    begin
        if (do_push)
        begin
            buf_q[wr_ptr] <= push_rec;
        end
    end

    always_ff @(posedge bram_clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: fb_writer/fb_writer.sv
`timescale 1ns/100ps
`default_nettype none

`include "gl_params.svh"

module fb_writer
    import gl_pixel_pkg::*, gl_mem_pkg::*;
(
    input  wire logic       bram_clk,
    input  wire logic       rst_n,
    input  wire logic       empty,
    input  wire pixel_rec_t head_rec,
    output logic            pop,
    output logic            wr_req,
    output fb_addr_t        wr_addr,
    output fb_word_t        wr_data,
    input  wire logic       wr_gnt,
    output logic            writer_idle
);

    typedef enum logic {
        WR_IDLE = 1'b0,
        WR_REQ  = 1'b1
    } wr_state_e;

    wr_state_e state;
    fb_addr_t  addr_q;
    fb_word_t  data_q;

    assign wr_req      = (state == WR_REQ);
    assign wr_addr     = addr_q;
    assign wr_data     = data_q;
    assign writer_idle = (state == WR_IDLE);

    // The record stays at the FIFO head until its write is granted
    assign pop = wr_req & wr_gnt;

    ////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////

    always_ff @(posedge bram_clk)
    begin
        if (!rst_n)
        begin
            state <= WR_IDLE;
        end
        else
        begin
            case (state)
                WR_IDLE:
                begin
                    if (!empty)
                        state <= WR_REQ;
                end
                WR_REQ:
                begin
                    if (wr_gnt)
                        state <= WR_IDLE;
                end
                default:
                begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    // Linear address, row major
    always_ff @(posedge bram_clk)
    begin
        if (state == WR_IDLE && !empty)
        begin
            addr_q <= fb_addr_t'(head_rec.y * `GL_FB_WIDTH + head_rec.x);
            data_q <= fb_word_t'(head_rec.color);
        end
    end

endmodule

`default_nettype wire

// File: hw/fb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module fb_arbiter
    import gl_mem_pkg::*;
(
    input  wire logic     bram_clk,
    input  wire logic     rst_n,
    input  wire logic     bram_a_en,
    input  wire logic     bram_a_we,
    input  wire fb_addr_t bram_a_addr,
    input  wire fb_word_t bram_a_din,
    input  wire logic     wr_req,
    input  wire fb_addr_t wr_addr,
    input  wire fb_word_t wr_data,
    output logic          wr_gnt,
    output logic          mem_en,
    output logic          mem_we,
    output fb_addr_t      mem_addr,
    output fb_word_t      mem_din
);

    fb_master_e last_owner;

    // Host always wins, the writer waits
    assign wr_gnt = wr_req & ~bram_a_en;

    assign mem_en   = bram_a_en | wr_gnt;
    assign mem_we   = bram_a_en ? bram_a_we : wr_gnt;
    assign mem_addr = bram_a_en ? bram_a_addr : wr_addr;
    assign mem_din  = bram_a_en ? bram_a_din : wr_data;

    // Owner of the most recent RAM access
    always_ff @(posedge bram_clk)
    begin
        if (!rst_n)
        begin
            last_owner <= FB_MASTER_HOST;
        end
        else if (bram_a_en)
        begin
            last_owner <= FB_MASTER_HOST;
        end
        else if (wr_gnt)
        begin
            last_owner <= FB_MASTER_WRITER;
        end
    end

endmodule

`default_nettype wire

// File: hw/fb_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "gl_params.svh"

module fb_mem
    import gl_mem_pkg::*;
(
    input  wire logic     bram_clk,
    input  wire logic     mem_en,
    input  wire logic     mem_we,
    input  wire fb_addr_t mem_addr,
    input  wire fb_word_t mem_din,
    output fb_word_t      bram_a_dout
);

    localparam int WORDS = `GL_FB_WIDTH * `GL_FB_HEIGHT;

    fb_word_t ram [WORDS];

    ////////////////////////////////////////
    // Single port, read before write
    ////////////////////////////////////////

    always_ff @(posedge bram_clk)
    begin
        if (mem_en)
        begin
            if (mem_we)
            begin
                ram[mem_addr] <= mem_din;
            end
            bram_a_dout <= ram[mem_addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/gl_core.sv
`timescale 1ns/100ps
`default_nettype none

module gl_core
    import gl_pixel_pkg::*, gl_mem_pkg::*;
(
    input  wire logic     bram_clk,
    input  wire logic     rst_n,
    input  wire logic     draw_start,
    input  wire coord_t   draw_x0,
    input  wire coord_t   draw_y0,
    input  wire coord_t   draw_x1,
    input  wire coord_t   draw_y1,
    input  wire color_t   draw_color,
    output logic          draw_busy,
    input  wire logic     bram_a_en,
    input  wire logic     bram_a_we,
    input  wire fb_addr_t bram_a_addr,
    input  wire fb_word_t bram_a_din,
    output fb_word_t      bram_a_dout
);

    // Raster to FIFO
    logic       push;
    pixel_rec_t push_rec;
    logic       full;

    // FIFO to writer
    logic       empty;
    pixel_rec_t head_rec;
    logic       pop;
    logic       writer_idle;

    // Writer to arbiter
    logic       wr_req;
    logic       wr_gnt;
    fb_addr_t   wr_addr;
    fb_word_t   wr_data;

    // Arbiter to RAM
    logic       mem_en;
    logic       mem_we;
    fb_addr_t   mem_addr;
    fb_word_t   mem_din;

    rect_raster i_rect_raster (
        .bram_clk    (bram_clk),
        .rst_n       (rst_n),
        .draw_start  (draw_start),
        .draw_x0     (draw_x0),
        .draw_y0     (draw_y0),
        .draw_x1     (draw_x1),
        .draw_y1     (draw_y1),
        .draw_color  (draw_color),
        .full        (full),
        .fifo_empty  (empty),
        .writer_idle (writer_idle),
        .push        (push),
        .push_rec    (push_rec),
        .draw_busy   (draw_busy)
    );

    pixel_fifo i_pixel_fifo (
        .bram_clk (bram_clk),
        .rst_n    (rst_n),
        .push     (push),
        .push_rec (push_rec),
        .pop      (pop),
        .head_rec (head_rec),
        .full     (full),
        .empty    (empty)
    );

    fb_writer i_fb_writer (
        .bram_clk    (bram_clk),
        .rst_n       (rst_n),
        .empty       (empty),
        .head_rec    (head_rec),
        .pop         (pop),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_gnt      (wr_gnt),
        .writer_idle (writer_idle)
    );

    fb_arbiter i_fb_arbiter (
        .bram_clk    (bram_clk),
        .rst_n       (rst_n),
        .bram_a_en   (bram_a_en),
        .bram_a_we   (bram_a_we),
        .bram_a_addr (bram_a_addr),
        .bram_a_din  (bram_a_din),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_gnt      (wr_gnt),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_din     (mem_din)
    );

    fb_mem i_fb_mem (
        .bram_clk    (bram_clk),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_din     (mem_din),
        .bram_a_dout (bram_a_dout)
    );

endmodule

`default_nettype wire

// File: verification/gl_core_sva.sv
`timescale 1ns/100ps
`default_nettype none

module gl_core_sva
    import gl_mem_pkg::*;
(
    input  wire logic       bram_clk,
    input  wire logic       rst_n,
    input  wire logic       bram_a_en,
    input  wire logic       wr_req,
    input  wire logic       wr_gnt,
    input  wire fb_addr_t   wr_addr,
    input  wire fb_word_t   wr_data,
    input  wire fb_master_e last_owner
);

    int fail_count;

    initial
    begin
        fail_count = 0;
    end

    // Host port has the RAM to itself
    a_host_excludes_gnt: assert property (
        @(posedge bram_clk) disable iff (!rst_n)
        !(wr_gnt && bram_a_en)
    ) else
    begin
        fail_count++;
        $error("wr_gnt high together with bram_a_en");
    end

    a_gnt_needs_req: assert property (
        @(posedge bram_clk) disable iff (!rst_n)
        wr_gnt |-> wr_req
    ) else
    begin
        fail_count++;
        $error("wr_gnt without wr_req");
    end

    // Pending request keeps its address and data
    a_req_held: assert property (
        @(posedge bram_clk) disable iff (!rst_n)
        (wr_req && !wr_gnt) |=> (wr_req && $stable(wr_addr) && $stable(wr_data))
    ) else
    begin
        fail_count++;
        $error("writer request changed before its grant");
    end

    // One write in flight so the writer rests a cycle after its grant
    a_writer_rests: assert property (
        @(posedge bram_clk) disable iff (!rst_n)
        (last_owner == FB_MASTER_WRITER && $past(wr_gnt)) |-> !wr_req
    ) else
    begin
        fail_count++;
        $error("writer requested again right after its grant");
    end

endmodule

bind fb_arbiter gl_core_sva i_gl_core_sva (
    .bram_clk   (bram_clk),
    .rst_n      (rst_n),
    .bram_a_en  (bram_a_en),
    .wr_req     (wr_req),
    .wr_gnt     (wr_gnt),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .last_owner (last_owner)
);

`default_nettype wire

// File: verification/gl_core_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "gl_params.svh"

module gl_core_checker
    import gl_pixel_pkg::*, gl_mem_pkg::*;
(
    input  wire logic     bram_clk,
    input  wire logic     rst_n,
    input  wire logic     draw_start,
    input  wire coord_t   draw_x0,
    input  wire coord_t   draw_y0,
    input  wire coord_t   draw_x1,
    input  wire coord_t   draw_y1,
    input  wire color_t   draw_color,
    input  wire logic     draw_busy,
    input  wire logic     bram_a_en,
    input  wire logic     bram_a_we,
    input  wire fb_addr_t bram_a_addr,
    input  wire fb_word_t bram_a_din,
    input  wire fb_word_t bram_a_dout,
    output int            error_count,
    output int            read_count
);

    localparam int WORDS = `GL_FB_WIDTH * `GL_FB_HEIGHT;

    fb_word_t model [WORDS];
    logic     rd_pend;
    fb_addr_t rd_addr;
    fb_word_t rd_exp;

    initial
    begin
        error_count = 0;
        read_count  = 0;
    end

    ////////////////////////////////////////
    // Reference framebuffer
    ////////////////////////////////////////

    always @(posedge bram_clk)
    begin
        if (!rst_n)
        begin
            rd_pend <= 1'b0;
        end
        else
        begin
            // Reads during a draw race the writer, only idle reads are scored
            rd_pend <= bram_a_en & ~bram_a_we & ~draw_busy;
            rd_addr <= bram_a_addr;
            rd_exp  <= model[bram_a_addr];
            if (bram_a_en && bram_a_we)
                model[bram_a_addr] = bram_a_din;
            // Accepted start paints the whole rectangle at once
            if (draw_start && !draw_busy)
            begin
                for (int y = int'(draw_y0); y <= int'(draw_y1); y++)
                    for (int x = int'(draw_x0); x <= int'(draw_x1); x++)
                        model[y * `GL_FB_WIDTH + x] = draw_color;
            end
        end
    end

    // Read data settles one cycle after the enable
    always @(negedge bram_clk)
    begin
        if (rd_pend)
        begin
            read_count++;
            if (bram_a_dout !== rd_exp)
            begin
                error_count++;
                $display("** Error at time %0t: bram_a_dout[%0d] expected %08h actual %08h",
                         $time, rd_addr, rd_exp, bram_a_dout);
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/gl_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "gl_params.svh"

module gl_core_tb
    import gl_pixel_pkg::*, gl_mem_pkg::*;
;

    localparam int WORDS           = `GL_FB_WIDTH * `GL_FB_HEIGHT;
    localparam int N_TESTS         = 6;
    localparam int DRAW_LIMIT      = WORDS * 3;
    localparam int WATCHDOG_CYCLES = N_TESTS * (WORDS * 3 + 200);

    typedef struct {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        color_t color;
        logic   clear;
        color_t clear_color;
        logic   traffic;
        logic   late_start;
    } test_t;

    logic     bram_clk;
    logic     rst_n;
    logic     draw_start;
    coord_t   draw_x0;
    coord_t   draw_y0;
    coord_t   draw_x1;
    coord_t   draw_y1;
    color_t   draw_color;
    logic     draw_busy;
    logic     bram_a_en;
    logic     bram_a_we;
    fb_addr_t bram_a_addr;
    fb_word_t bram_a_din;
    fb_word_t bram_a_dout;

    test_t       tests [N_TESTS];
    string       names [N_TESTS];
    logic [15:0] lfsr;
    int          tb_errors;
    int          chk_errors;
    int          chk_reads;

    gl_core i_gl_core (
        .bram_clk    (bram_clk),
        .rst_n       (rst_n),
        .draw_start  (draw_start),
        .draw_x0     (draw_x0),
        .draw_y0     (draw_y0),
        .draw_x1     (draw_x1),
        .draw_y1     (draw_y1),
        .draw_color  (draw_color),
        .draw_busy   (draw_busy),
        .bram_a_en   (bram_a_en),
        .bram_a_we   (bram_a_we),
        .bram_a_addr (bram_a_addr),
        .bram_a_din  (bram_a_din),
        .bram_a_dout (bram_a_dout)
    );

    gl_core_checker i_gl_core_checker (
        .bram_clk    (bram_clk),
        .rst_n       (rst_n),
        .draw_start  (draw_start),
        .draw_x0     (draw_x0),
        .draw_y0     (draw_y0),
        .draw_x1     (draw_x1),
        .draw_y1     (draw_y1),
        .draw_color  (draw_color),
        .draw_busy   (draw_busy),
        .bram_a_en   (bram_a_en),
        .bram_a_we   (bram_a_we),
        .bram_a_addr (bram_a_addr),
        .bram_a_din  (bram_a_din),
        .bram_a_dout (bram_a_dout),
        .error_count (chk_errors),
        .read_count  (chk_reads)
    );

    initial
    begin
        bram_clk = 1'b0;
        forever #2 bram_clk = ~bram_clk;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge bram_clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // Failures from the checker, the sequence and the bound assertions
    function automatic int error_total();
        return chk_errors + tb_errors + i_gl_core.i_fb_arbiter.i_gl_core_sva.fail_count;
    endfunction

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val  = {val[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic set_test(input int idx, input string name, input int x0, input int y0,
                            input int x1, input int y1, input color_t color,
                            input logic clear, input color_t clear_color,
                            input logic traffic, input logic late_start);
        names[idx] = name;
        tests[idx] = '{coord_t'(x0), coord_t'(y0), coord_t'(x1), coord_t'(y1), color,
                       clear, clear_color, traffic, late_start};
    endtask

    task automatic load_tests();
        set_test(0, "single fill", 3, 2, 20, 9, 32'h00FF_8800, 1'b1, 32'h1000_0000, 1'b0, 1'b0);
        set_test(1, "overlap", 12, 6, 40, 20, 32'h0000_77EE, 1'b0, 32'h0, 1'b0, 1'b0);
        set_test(2, "contention", 5, 4, 36, 27, 32'hA5A5_0F0F, 1'b1, 32'h2000_0000, 1'b1, 1'b0);
        set_test(3, "busy rule", 50, 1, 60, 12, 32'h1234_5678, 1'b1, 32'h3000_0000, 1'b0, 1'b1);
        set_test(4, "degenerate", 30, 3, 10, 8, 32'hFFFF_FFFF, 1'b1, 32'h4000_0000, 1'b0, 1'b0);
        set_test(5, "edge row", 0, 31, 63, 31, 32'h0BAD_CAFE, 1'b1, 32'h5000_0000, 1'b1, 1'b0);
    endtask

    // Background pattern depends on every address bit
    task automatic clear_fb(input color_t clear_color);
        for (int a = 0; a < WORDS; a++)
        begin
            @(negedge bram_clk);
            bram_a_en   = 1'b1;
            bram_a_we   = 1'b1;
            bram_a_addr = fb_addr_t'(a);
            bram_a_din  = clear_color ^ 32'(a);
        end
        @(negedge bram_clk);
        bram_a_en = 1'b0;
        bram_a_we = 1'b0;
    endtask

    task automatic run_draw(input int idx, output int busy_cycles);
        logic [15:0] bits;
        int          waited;
        busy_cycles = 0;
        waited      = 0;
        @(negedge bram_clk);
        draw_x0    = tests[idx].x0;
        draw_y0    = tests[idx].y0;
        draw_x1    = tests[idx].x1;
        draw_y1    = tests[idx].y1;
        draw_color = tests[idx].color;
        draw_start = 1'b1;
        @(negedge bram_clk);
        draw_start = 1'b0;
        if (draw_busy !== 1'b1)
        begin
            $display("draw_busy did not rise the cycle after draw_start in test %0d", idx);
            tb_errors++;
        end
        if (tests[idx].late_start)
        begin
            // Full screen start while busy must be dropped
            draw_x0    = 8'd0;
            draw_y0    = 8'd0;
            draw_x1    = 8'd63;
            draw_y1    = 8'd31;
            draw_color = ~tests[idx].color;
            draw_start = 1'b1;
        end
        while (draw_busy && waited < DRAW_LIMIT)
        begin
            busy_cycles++;
            bram_a_en = 1'b0;
            if (tests[idx].traffic)
            begin
                take_bits(1, bits);
                if (bits[0])
                begin
                    take_bits(11, bits);
                    bram_a_en   = 1'b1;
                    bram_a_we   = 1'b0;
                    bram_a_addr = fb_addr_t'(bits[10:0]);
                end
            end
            @(negedge bram_clk);
            draw_start = 1'b0;
            waited++;
        end
        bram_a_en = 1'b0;
        if (draw_busy)
        begin
            $display("draw_busy still high after %0d cycles in test %0d", DRAW_LIMIT, idx);
            tb_errors++;
        end
    endtask

    task automatic read_back();
        for (int a = 0; a < WORDS; a++)
        begin
            @(negedge bram_clk);
            bram_a_en   = 1'b1;
            bram_a_we   = 1'b0;
            bram_a_addr = fb_addr_t'(a);
        end
        @(negedge bram_clk);
        bram_a_en = 1'b0;
        @(negedge bram_clk);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        int   prev_errors;
        int   test_errors;
        int   busy_cycles;
        logic empty_rect;
        rst_n       = 1'b0;
        draw_start  = 1'b0;
        draw_x0     = '0;
        draw_y0     = '0;
        draw_x1     = '0;
        draw_y1     = '0;
        draw_color  = '0;
        bram_a_en   = 1'b0;
        bram_a_we   = 1'b0;
        bram_a_addr = '0;
        bram_a_din  = '0;
        lfsr        = 16'd10;
        tb_errors   = 0;
        load_tests();
        repeat (16) @(posedge bram_clk);
        @(negedge bram_clk);
        rst_n = 1'b1;
        @(negedge bram_clk);
        if (draw_busy !== 1'b0)
        begin
            $display("draw_busy is not low after reset");
            tb_errors++;
        end
        for (int t = 0; t < N_TESTS; t++)
        begin
            prev_errors = error_total();
            if (tests[t].clear)
                clear_fb(tests[t].clear_color);
            run_draw(t, busy_cycles);
            empty_rect = (tests[t].x0 > tests[t].x1) || (tests[t].y0 > tests[t].y1);
            if (empty_rect && busy_cycles != 1)
            begin
                $display("Empty rectangle kept draw_busy high for %0d cycles, expected 1",
                         busy_cycles);
                tb_errors++;
            end
            read_back();
            test_errors = error_total() - prev_errors;
            $display("test %0d %s: %s (%0d errors)", t, names[t],
                     (test_errors == 0) ? "ok" : "mismatch", test_errors);
        end
        $display("%0d tests, %0d reads compared, %0d errors", N_TESTS, chk_reads,
                 error_total());
        if (error_total() == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/gl_pixel_pkg.sv
common/gl_mem_pkg.sv
hw/rect_raster.sv
hw/pixel_fifo.sv
fb_writer/fb_writer.sv
hw/fb_arbiter.sv
hw/fb_mem.sv
hw/gl_core.sv
verification/gl_core_sva.sv
verification/gl_core_checker.sv
verification/gl_core_tb.sv

// File: Makefile
# Verilator flow for the pixel-fill subsystem

VERILATOR ?= verilator
TOP       ?= gl_core_tb
RTL_TOP   ?= gl_core
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
